// ==== project.f ====
rtl/switch_pkg.sv
rtl/switch_ctrl_pkg.sv
rtl/frame_queue_if.sv
rtl/frame_queue.sv
rtl/gmii_rx_framer.sv
rtl/flow_table.sv
rtl/forwarder.sv
rtl/tx_mixer.sv
rtl/switch_top.sv
tb/switch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module switch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vswitch_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// ==== tb/switch_tb.sv ====
// Runs switch_top at its default parameters and expects each test's frames within 5000 cycles
`timescale 1ns/10ps

module switch_tb;
  import switch_pkg::*;
  import switch_ctrl_pkg::*;

  localparam int NPORT    = 4;
  localparam int NX       = NPORT * NPORT;
  localparam int MAX_LEN  = 64;
  localparam int TX_GAP   = 8;
  localparam int NTEST    = 10;
  localparam int WAIT_MAX = 5000;
  localparam int SETTLE   = 200;

  // One table row holds config command, sending inputs, frames per input, length and seed
  typedef struct packed {
    flow_op_e         op;
    logic [1:0]       port;
    logic [NPORT-1:0] mask;
    logic [NPORT-1:0] src_mask;
    int               nfr;
    int               len;
    pkt_byte_t        seed;
    logic             rnd;
  } test_entry_t;

  logic                  sys_clk;
  logic                  rst_n;
  pkt_byte_t [NPORT-1:0] gmii_rxd;
  logic [NPORT-1:0]      gmii_rx_dv;
  pkt_byte_t [NPORT-1:0] gmii_txd;
  logic [NPORT-1:0]      gmii_tx_en;
  logic                  cfg_valid;
  flow_op_e              cfg_op;
  logic [1:0]            cfg_port;
  logic [NPORT-1:0]      cfg_mask;

  test_entry_t      tbl [NTEST];
  logic [NPORT-1:0] mdl_mask [NPORT];
  // Expected frames indexed by out*NPORT+in
  pkt_byte_t        exp_data [NX][$];
  int               exp_len [NX][$];
  pkt_byte_t        got_data [NPORT][$];
  int               got_len [NPORT][$];
  logic [8:0]       stream [NPORT][$];
  bit               in_frame [NPORT];
  bit               seen_frame [NPORT];
  int               idle_cnt [NPORT];
  int               cur_len [NPORT];
  int               err_cnt;
  int               chk_cnt;

  switch_top i_dut (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .gmii_rxd   (gmii_rxd),
    .gmii_rx_dv (gmii_rx_dv),
    .gmii_txd   (gmii_txd),
    .gmii_tx_en (gmii_tx_en),
    .cfg_valid  (cfg_valid),
    .cfg_op     (cfg_op),
    .cfg_port   (cfg_port),
    .cfg_mask   (cfg_mask)
  );

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  task automatic check_byte(string name, pkt_byte_t got, pkt_byte_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_gap(string name, int got, int min_gap);
    chk_cnt++;
    if (got < min_gap) begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s got %0d expected at least %0d",
               $time, name, got, min_gap);
    end
  endtask

  //--------------------------------------------------------------------------
  // Transmit monitor where one burst of gmii_tx_en is one frame
  //--------------------------------------------------------------------------
  always @(negedge sys_clk) begin
    if (rst_n) begin
      for (int o = 0; o < NPORT; o++) begin
        if (gmii_tx_en[o]) begin
          if (!in_frame[o] && seen_frame[o])
            check_gap($sformatf("gmii_tx_en[%0d] low cycles", o), idle_cnt[o], TX_GAP);
          if (!in_frame[o]) cur_len[o] = 0;
          in_frame[o] = 1'b1;
          got_data[o].push_back(gmii_txd[o]);
          cur_len[o]++;
        end else begin
          if (in_frame[o]) begin
            got_len[o].push_back(cur_len[o]);
            seen_frame[o] = 1'b1;
            idle_cnt[o]   = 0;
          end
          in_frame[o] = 1'b0;
          idle_cnt[o]++;
        end
      end
    end
  end

  // Mask model clears the source bit on every opcode
  task automatic apply_cfg(test_entry_t e);
    logic [NPORT-1:0] src_bit;
    src_bit = NPORT'(1) << e.port;
    if (e.op == FLOW_SET) mdl_mask[e.port] = e.mask & ~src_bit;
    if (e.op == FLOW_FLOOD) mdl_mask[e.port] = ~src_bit;
    if (e.op == FLOW_DROP) mdl_mask[e.port] = '0;
    if (e.op != FLOW_NOP) begin
      @(posedge sys_clk);
      #1;
      cfg_valid = 1'b1;
      cfg_op    = e.op;
      cfg_port  = e.port;
      cfg_mask  = e.mask;
      @(posedge sys_clk);
      #1;
      cfg_valid = 1'b0;
      cfg_op    = FLOW_NOP;
    end
  endtask

  task automatic build_frames(test_entry_t e);
    pkt_byte_t b;
    pkt_byte_t tag;
    int        flen;
    int        keep;
    for (int s = 0; s < NPORT; s++) begin
      for (int k = 0; k < e.nfr && e.src_mask[s]; k++) begin
        flen = e.len + 5 * k;
        keep = (flen > MAX_LEN) ? MAX_LEN : flen;
        // First byte tags the frame by input and index
        tag  = pkt_byte_t'(int'(e.seed) + 16 * s + 4 * k);
        for (int o = 0; o < NPORT; o++)
          if (mdl_mask[s][o]) exp_len[o*NPORT+s].push_back(keep);
        for (int i = 0; i < flen; i++) begin
          b = (e.rnd && i > 0) ? pkt_byte_t'($urandom) : pkt_byte_t'(int'(tag) + i);
          stream[s].push_back({1'b1, b});
          for (int o = 0; o < NPORT; o++)
            if (mdl_mask[s][o] && i < keep) exp_data[o*NPORT+s].push_back(b);
        end
        stream[s].push_back(9'h000);
        stream[s].push_back(9'h000);
      end
    end
  endtask

  task automatic drive_streams();
    logic [8:0] w;
    bit         busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge sys_clk);
      #1;
      busy = 1'b0;
      for (int p = 0; p < NPORT; p++) begin
        gmii_rx_dv[p] = 1'b0;
        if (stream[p].size() > 0) begin
          w             = stream[p].pop_front();
          gmii_rx_dv[p] = w[8];
          gmii_rxd[p]   = w[7:0];
          busy          = 1'b1;
        end
      end
    end
  endtask

  function automatic int expected_frames(int o);
    int n;
    n = 0;
    for (int s = 0; s < NPORT; s++) n += exp_len[o*NPORT+s].size();
    return n;
  endfunction

  task automatic wait_frames(output bit ok);
    bit done;
    ok = 1'b0;
    for (int cyc = 0; cyc < WAIT_MAX && !ok; cyc++) begin
      @(posedge sys_clk);
      done = 1'b1;
      for (int o = 0; o < NPORT; o++)
        if (got_len[o].size() < expected_frames(o)) done = 1'b0;
      ok = done;
    end
    // Quiet period catches frames that should not appear
    if (ok) repeat (SETTLE) @(posedge sys_clk);
  endtask

  task automatic check_outputs();
    int        glen;
    int        elen;
    int        src;
    pkt_byte_t g;
    for (int o = 0; o < NPORT; o++) begin
      check_count($sformatf("frame count on port %0d", o), got_len[o].size(),
                  expected_frames(o));
      while (got_len[o].size() > 0) begin
        glen = got_len[o].pop_front();
        src  = -1;
        for (int s = 0; s < NPORT; s++)
          if (src < 0 && exp_len[o*NPORT+s].size() > 0 &&
              exp_data[o*NPORT+s][0] == got_data[o][0])
            src = s;
        elen = (src < 0) ? 0 : exp_len[o*NPORT+src].pop_front();
        if (src < 0) begin
          err_cnt++;
          $display("Frame of %0d bytes on port %0d matches no pending input frame", glen, o);
        end else begin
          check_count($sformatf("frame length port %0d from %0d", o, src), glen, elen);
        end
        for (int i = 0; i < glen || i < elen; i++) begin
          g = (i < glen) ? got_data[o].pop_front() : 8'h00;
          if (i < elen && i < glen)
            check_byte($sformatf("gmii_txd[%0d] byte %0d", o, i), g, exp_data[o*NPORT+src][0]);
          if (i < elen) g = exp_data[o*NPORT+src].pop_front();
        end
      end
      for (int s = 0; s < NPORT; s++) begin
        exp_len[o*NPORT+s].delete();
        exp_data[o*NPORT+s].delete();
      end
    end
  endtask

  initial begin
    int          err_before;
    bit          ok;
    bit          timed_out;
    void'($urandom(70));
    rst_n      = 1'b0;
    cfg_valid  = 1'b0;
    cfg_op     = FLOW_NOP;
    cfg_port   = '0;
    cfg_mask   = '0;
    gmii_rxd   = '0;
    gmii_rx_dv = '0;
    err_cnt    = 0;
    chk_cnt    = 0;
    timed_out  = 1'b0;
    for (int p = 0; p < NPORT; p++) mdl_mask[p] = ~(NPORT'(1) << p);
    tbl[0] = '{FLOW_NOP,   2'd0, 4'b0000, 4'b0001, 1, 20, 8'h10, 1'b0};
    tbl[1] = '{FLOW_SET,   2'd1, 4'b1011, 4'b0010, 1, 30, 8'h40, 1'b1};
    tbl[2] = '{FLOW_DROP,  2'd1, 4'b0000, 4'b0010, 1, 25, 8'h50, 1'b0};
    tbl[3] = '{FLOW_FLOOD, 2'd1, 4'b0000, 4'b0010, 1, 17, 8'h58, 1'b0};
    tbl[4] = '{FLOW_SET,   2'd2, 4'b0010, 4'b0100, 4, 12, 8'h60, 1'b1};
    tbl[5] = '{FLOW_SET,   2'd1, 4'b0001, 4'b0000, 0, 0,  8'h00, 1'b0};
    tbl[6] = '{FLOW_SET,   2'd3, 4'b0001, 4'b0000, 0, 0,  8'h00, 1'b0};
    tbl[7] = '{FLOW_SET,   2'd2, 4'b0001, 4'b1110, 2, 33, 8'h80, 1'b0};
    tbl[8] = '{FLOW_NOP,   2'd0, 4'b0000, 4'b1000, 1, 80, 8'hA0, 1'b0};
    tbl[9] = '{FLOW_FLOOD, 2'd3, 4'b0000, 4'b1000, 3, 40, 8'hC0, 1'b1};
    repeat (3) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;
    for (int n = 0; n < NTEST && !timed_out; n++) begin
      err_before = err_cnt;
      apply_cfg(tbl[n]);
      build_frames(tbl[n]);
      drive_streams();
      wait_frames(ok);
      if (ok) begin
        check_outputs();
      end else begin
        timed_out = 1'b1;
        err_cnt++;
        $display("Timed out waiting for output frames in test %0d", n);
      end
      $display("test %0d %s, %0d errors", n, (err_cnt == err_before) ? "ok" : "bad",
               err_cnt - err_before);
    end
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/switch_top.sv ====
// Single sys_clk domain with synchronous active-low reset and NPORT of at least 2
`timescale 1ns/10ps

module switch_top #(
  parameter int NPORT         = 4,
  parameter int QUEUE_AW      = 7,
  parameter int MAX_FRAME_LEN = 64,
  parameter int TX_GAP        = 8
) (
  input  logic                                sys_clk,
  input  logic                                rst_n,
  input  switch_pkg::pkt_byte_t [NPORT-1:0]   gmii_rxd,
  input  logic [NPORT-1:0]                    gmii_rx_dv,
  output switch_pkg::pkt_byte_t [NPORT-1:0]   gmii_txd,
  output logic [NPORT-1:0]                    gmii_tx_en,
  input  logic                                cfg_valid,
  input  switch_ctrl_pkg::flow_op_e           cfg_op,
  input  logic [$clog2(NPORT)-1:0]            cfg_port,
  input  logic [NPORT-1:0]                    cfg_mask
);
  import switch_pkg::*;

  localparam int NX = NPORT * NPORT;

  logic [NPORT-1:0][NPORT-1:0] fwd_mask;
  // Crossbar read side, entry i*NPORT+o links input i to output o
  queue_word_t [NX-1:0]        xq_dout;
  logic [NX-1:0]               xq_empty;
  logic [NX-1:0]               xq_avail;
  logic [NX-1:0]               xq_rd;

  flow_table #(.NPORT(NPORT)) u_flow_table (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_op    (cfg_op),
    .cfg_port  (cfg_port),
    .cfg_mask  (cfg_mask),
    .fwd_mask  (fwd_mask)
  );

  //--------------------------------------------------------------------------
  // Receive side and crossbar queues, per input
  //--------------------------------------------------------------------------
  for (genvar i = 0; i < NPORT; i++) begin : g_in
    frame_queue_if #(.QUEUE_AW(QUEUE_AW)) rx_q ();
    frame_queue_if #(.QUEUE_AW(QUEUE_AW)) tx_q [NPORT] ();

    gmii_rx_framer #(.MAX_FRAME_LEN(MAX_FRAME_LEN)) u_framer (
      .sys_clk    (sys_clk),
      .rst_n      (rst_n),
      .gmii_rxd   (gmii_rxd[i]),
      .gmii_rx_dv (gmii_rx_dv[i]),
      .q          (rx_q)
    );

    frame_queue #(.QUEUE_AW(QUEUE_AW)) u_rx_queue (
      .sys_clk (sys_clk),
      .rst_n   (rst_n),
      .q       (rx_q)
    );

    forwarder #(.NPORT(NPORT), .MAX_FRAME_LEN(MAX_FRAME_LEN)) u_forwarder (
      .sys_clk  (sys_clk),
      .rst_n    (rst_n),
      .fwd_mask (fwd_mask[i]),
      .rx_q     (rx_q),
      .tx_q     (tx_q)
    );

    for (genvar o = 0; o < NPORT; o++) begin : g_xq
      frame_queue #(.QUEUE_AW(QUEUE_AW)) u_xq (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .q       (tx_q[o])
      );

      assign xq_dout[i*NPORT+o]  = tx_q[o].dout;
      assign xq_empty[i*NPORT+o] = tx_q[o].empty;
      assign xq_avail[i*NPORT+o] = tx_q[o].frame_avail;
      assign tx_q[o].rd_en       = xq_rd[i*NPORT+o];
    end
  end

  //--------------------------------------------------------------------------
  // Transmit side, per output
  //--------------------------------------------------------------------------
  for (genvar o = 0; o < NPORT; o++) begin : g_out
    frame_queue_if #(.QUEUE_AW(QUEUE_AW)) mix_q [NPORT] ();

    for (genvar i = 0; i < NPORT; i++) begin : g_link
      assign mix_q[i].dout        = xq_dout[i*NPORT+o];
      assign mix_q[i].empty       = xq_empty[i*NPORT+o];
      assign mix_q[i].frame_avail = xq_avail[i*NPORT+o];
      assign xq_rd[i*NPORT+o]     = mix_q[i].rd_en;
    end

    tx_mixer #(.NPORT(NPORT), .TX_GAP(TX_GAP)) u_mixer (
      .sys_clk    (sys_clk),
      .rst_n      (rst_n),
      .in_q       (mix_q),
      .gmii_txd   (gmii_txd[o]),
      .gmii_tx_en (gmii_tx_en[o])
    );
  end

endmodule

// ==== rtl/tx_mixer.sv ====
// TX_GAP must be at least 1 and a frame is only started once it is fully stored
`timescale 1ns/10ps

module tx_mixer #(
  parameter int NPORT  = 4,
  parameter int TX_GAP = 8
) (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  frame_queue_if.reader         in_q [NPORT],
  output switch_pkg::pkt_byte_t gmii_txd,
  output logic                  gmii_tx_en
);
  import switch_pkg::*;
  import switch_ctrl_pkg::*;

  localparam int PW    = $clog2(NPORT);
  localparam int GAP_W = $clog2(TX_GAP + 1);

  mix_state_e              state;
  logic [PW-1:0]           rr_ptr;
  logic [PW-1:0]           pick;
  logic                    pick_valid;
  logic [GAP_W-1:0]        gap_cnt;
  logic [NPORT-1:0]        avail;
  logic [NPORT-1:0]        nonempty;
  queue_word_t [NPORT-1:0] head;
  queue_word_t             cur_word;
  logic                    rd_go;

  for (genvar i = 0; i < NPORT; i++) begin : g_in
    assign avail[i]      = in_q[i].frame_avail;
    assign nonempty[i]   = !in_q[i].empty;
    assign head[i]       = in_q[i].dout;
    assign in_q[i].rd_en = rd_go && (rr_ptr == PW'(i));
  end

  assign cur_word = head[rr_ptr];
  assign rd_go    = (state == MIX_SEND) && nonempty[rr_ptr];

  // Round-robin scan from the input after the last one served
  always_comb begin
    int idx;
    pick_valid = 1'b0;
    pick       = rr_ptr;
    for (int k = 1; k <= NPORT; k++) begin
      idx = (int'(rr_ptr) + k) % NPORT;
      if (!pick_valid && avail[idx]) begin
        pick_valid = 1'b1;
        pick       = PW'(idx);
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      state      <= MIX_SELECT;
      rr_ptr     <= PW'(NPORT - 1);
      gap_cnt    <= '0;
      gmii_tx_en <= 1'b0;
    end else begin
      gmii_tx_en <= rd_go;
      case (state)
        MIX_SELECT: begin
          if (pick_valid) begin
            rr_ptr <= pick;
            state  <= MIX_SEND;
          end
        end
        MIX_SEND: begin
          if (rd_go && cur_word.last) begin
            gap_cnt <= '0;
            state   <= MIX_GAP;
          end
        end
        MIX_GAP: begin
          if (gap_cnt == GAP_W'(TX_GAP - 1)) begin
            state <= MIX_SELECT;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: state <= MIX_SELECT;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rd_go) begin
      gmii_txd <= cur_word.data;
    end
  end

  a_ifg: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $fell(gmii_tx_en) |-> !gmii_tx_en [*TX_GAP])
    else $error("tx_mixer interframe gap shorter than TX_GAP");

endmodule

// ==== rtl/forwarder.sv ====
// A frame waits until every selected output queue can take MAX_FRAME_LEN words
`timescale 1ns/10ps

module forwarder #(
  parameter int NPORT         = 4,
  parameter int MAX_FRAME_LEN = 64
) (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  logic [NPORT-1:0] fwd_mask,
  frame_queue_if.reader    rx_q,
  frame_queue_if.writer    tx_q [NPORT]
);
  import switch_ctrl_pkg::*;

  localparam int DEPTH = 1 << ($bits(tx_q[0].level) - 1);

  fwd_state_e       state;
  logic [NPORT-1:0] sel_mask;
  logic [NPORT-1:0] room_ok;
  logic [NPORT-1:0] tx_full;
  logic [NPORT-1:0] tx_wr;
  logic             rd_go;

  //--------------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------------
  assign rd_go       = ((state == FWD_COPY) || (state == FWD_DISCARD)) && !rx_q.empty;
  assign rx_q.rd_en  = rd_go;
  assign tx_wr       = ((state == FWD_COPY) && rd_go) ? sel_mask : '0;

  // Same head word goes to every selected crossbar queue
  for (genvar o = 0; o < NPORT; o++) begin : g_tx
    assign room_ok[o]     = int'(tx_q[o].level) <= DEPTH - MAX_FRAME_LEN;
    assign tx_full[o]     = tx_q[o].full;
    assign tx_q[o].din    = rx_q.dout;
    assign tx_q[o].wr_en  = tx_wr[o];
  end

  //--------------------------------------------------------------------------
  // Frame FSM
  //--------------------------------------------------------------------------
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      state    <= FWD_IDLE;
      sel_mask <= '0;
    end else begin
      case (state)
        FWD_IDLE: begin
          // Mask is frozen here for the whole frame
          if (rx_q.frame_avail) begin
            sel_mask <= fwd_mask;
            state    <= (fwd_mask == '0) ? FWD_DISCARD : FWD_WAIT_ROOM;
          end
        end
        FWD_WAIT_ROOM: begin
          if ((room_ok | ~sel_mask) == '1) begin
            state <= FWD_COPY;
          end
        end
        FWD_COPY, FWD_DISCARD: begin
          if (rd_go && rx_q.dout.last) begin
            state <= FWD_IDLE;
          end
        end
        default: state <= FWD_IDLE;
      endcase
    end
  end

  // Room check before each frame keeps writes on selected queues that are not full
  a_sel_only: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (tx_wr & ~(sel_mask & ~tx_full)) == '0)
    else $error("forwarder wrote outside its mask or into a full queue");

endmodule

// ==== rtl/flow_table.sv ====
// Needs NPORT of at least 2 and ignores commands that name a port at or above NPORT
`timescale 1ns/10ps

module flow_table #(
  parameter int NPORT = 4
) (
  input  logic                          sys_clk,
  input  logic                          rst_n,
  input  logic                          cfg_valid,
  input  switch_ctrl_pkg::flow_op_e     cfg_op,
  input  logic [$clog2(NPORT)-1:0]      cfg_port,
  input  logic [NPORT-1:0]              cfg_mask,
  output logic [NPORT-1:0][NPORT-1:0]   fwd_mask
);
  import switch_ctrl_pkg::*;

  logic [NPORT-1:0] src_bit;

  assign src_bit = NPORT'(1) << cfg_port;

  // Source port is never in its own mask
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NPORT; i++) begin
        fwd_mask[i] <= ~(NPORT'(1) << i);
      end
    end else if (cfg_valid && (int'(cfg_port) < NPORT)) begin
      case (cfg_op)
        FLOW_SET:   fwd_mask[cfg_port] <= cfg_mask & ~src_bit;
        FLOW_FLOOD: fwd_mask[cfg_port] <= ~src_bit;
        FLOW_DROP:  fwd_mask[cfg_port] <= '0;
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== rtl/gmii_rx_framer.sv ====
// Frames need one idle cycle between them and are dropped whole without MAX_FRAME_LEN free words
`timescale 1ns/10ps

module gmii_rx_framer #(
  parameter int MAX_FRAME_LEN = 64
) (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  switch_pkg::pkt_byte_t gmii_rxd,
  input  logic                  gmii_rx_dv,
  frame_queue_if.writer         q
);
  import switch_pkg::*;

  localparam int DEPTH = 1 << ($bits(q.level) - 1);
  localparam int CNT_W = $clog2(MAX_FRAME_LEN + 1);

  pkt_byte_t        hold_byte;
  logic             hold_valid;
  logic             rx_dv_d;
  logic             admit;
  logic [CNT_W-1:0] byte_cnt;
  logic             frame_start;
  logic             admit_now;
  logic [CNT_W-1:0] cnt_cur;
  logic             take;

  assign frame_start = gmii_rx_dv && !rx_dv_d;
  // Admission is decided once, on the first byte
  assign admit_now   = frame_start ? (int'(q.level) <= DEPTH - MAX_FRAME_LEN) : admit;
  assign cnt_cur     = frame_start ? '0 : byte_cnt;
  assign take        = gmii_rx_dv && admit_now && (cnt_cur < CNT_W'(MAX_FRAME_LEN));

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      rx_dv_d    <= 1'b0;
      admit      <= 1'b0;
      hold_valid <= 1'b0;
      byte_cnt   <= '0;
    end else begin
      rx_dv_d    <= gmii_rx_dv;
      admit      <= admit_now;
      hold_valid <= take;
      byte_cnt   <= take ? cnt_cur + 1'b1 : cnt_cur;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (take) begin
      hold_byte <= gmii_rxd;
    end
  end

  // Held byte is final when dv has dropped or the length cap was reached
  assign q.wr_en = hold_valid;
  assign q.din   = '{last: !gmii_rx_dv || (byte_cnt == CNT_W'(MAX_FRAME_LEN)),
                     data: hold_byte};

endmodule

// ==== rtl/frame_queue.sv ====
// Depth is a power of two and both sides must respect full and empty on their own
`timescale 1ns/10ps

module frame_queue #(
  parameter int QUEUE_AW = 7
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  frame_queue_if.fifo q
);
  import switch_pkg::*;

  localparam int DEPTH = 1 << QUEUE_AW;
  localparam int LW    = QUEUE_AW + 1;

  logic [QWORD_W-1:0]  mem [DEPTH];
  logic [QUEUE_AW-1:0] wr_ptr;
  logic [QUEUE_AW-1:0] rd_ptr;
  logic [LW-1:0]       level_q;
  // Stored words with last set, one per complete frame
  logic [LW-1:0]       last_cnt;

  always_ff @(posedge sys_clk) begin
    if (q.wr_en) begin
      mem[wr_ptr] <= q.din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level_q  <= '0;
      last_cnt <= '0;
    end else begin
      if (q.wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (q.rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      level_q  <= level_q + LW'(q.wr_en) - LW'(q.rd_en);
      last_cnt <= last_cnt + LW'(q.wr_en && q.din.last) - LW'(q.rd_en && q.dout.last);
    end
  end

  assign q.dout        = mem[rd_ptr];
  assign q.level       = level_q;
  assign q.empty       = (level_q == '0);
  assign q.full        = (level_q == LW'(DEPTH));
  assign q.frame_avail = (last_cnt != '0);

  a_no_overflow: assert property (@(posedge sys_clk) disable iff (!rst_n)
    q.wr_en |-> !q.full)
    else $error("frame_queue write while full");

  a_no_underflow: assert property (@(posedge sys_clk) disable iff (!rst_n)
    q.rd_en |-> !q.empty)
    else $error("frame_queue read while empty");

endmodule

// ==== rtl/frame_queue_if.sv ====
// Level is QUEUE_AW+1 bits so that a full queue of 2**QUEUE_AW words can be shown
`timescale 1ns/10ps

interface frame_queue_if #(
  parameter int QUEUE_AW = 7
);
  import switch_pkg::*;

  // Write side
  queue_word_t       din;
  logic              wr_en;
  logic              full;
  logic [QUEUE_AW:0] level;

  // Read side, first word falls through
  queue_word_t       dout;
  logic              empty;
  logic              rd_en;
  logic              frame_avail;

  modport writer (output din, output wr_en, input full, input level);
  modport reader (input dout, input empty, input frame_avail, output rd_en);
  modport fifo (
    input  din, wr_en, rd_en,
    output full, level, dout, empty, frame_avail
  );

endinterface

// ==== rtl/switch_ctrl_pkg.sv ====
// Flow opcodes and all state enums are 2 bits and must stay within that width
package switch_ctrl_pkg;

  // Flow table commands
  typedef enum logic [1:0] {
    FLOW_NOP,
    FLOW_SET,
    FLOW_FLOOD,
    FLOW_DROP
  } flow_op_e;

  typedef enum logic [1:0] {
    FWD_IDLE,
    FWD_WAIT_ROOM,
    FWD_COPY,
    FWD_DISCARD
  } fwd_state_e;

  typedef enum logic [1:0] {
    MIX_SELECT,
    MIX_SEND,
    MIX_GAP
  } mix_state_e;

endpackage

// ==== rtl/switch_pkg.sv ====
// The queue word is fixed at 9 bits and only its last flag marks where a frame ends
package switch_pkg;

  // Width of one stored queue word
  localparam int QWORD_W = 9;

  typedef logic [7:0] pkt_byte_t;

  // Last flag on top, byte below
  typedef struct packed {
    logic      last;
    pkt_byte_t data;
  } queue_word_t;

endpackage
